// ==== compile.f ====
+incdir+rtl
rtl/psl_buffer_pkg.sv
rtl/psl_response_pkg.sv
rtl/bw_split_queue.sv
rtl/br_latency_queue.sv
rtl/resp_hold_queue.sv
rtl/psl_buffer_top.sv
verification/tb_psl_buffer.sv

// ==== rtl/br_latency_queue.sv ====
`timescale 1ns/10ps
`include "psl_macros.svh"

module br_latency_queue import psl_buffer_pkg::*; (
  input  logic      ha_pclock,
  input  logic      rst,
  input  logic      host_brvalid,
  input  tag_t      host_brtag,
  output logic      host_rdvalid,
  output tag_t      host_rdtag,
  output line_t     host_rddata,
  output line_par_t host_rdpar,
  output logic      afu_brvalid,
  output tag_t      afu_brtag,
  output half_sel_e afu_brad,
  input  brlat_t    afu_brlat,
  input  half_t     afu_brdata,
  input  half_par_t afu_brpar
);

  tag_t                        tag_mem [`PSL_QDEPTH];
  logic [`PSL_QDEPTH_LOG2-1:0] wr_ptr;
  logic [`PSL_QDEPTH_LOG2-1:0] rd_ptr;
  half_sel_e                   br_half;
  logic                        lo_issue;
  logic                        hi_issue;
  logic                        rd_load;
  logic [`PSL_BRLAT_MAX:0]     dly_valid;
  tag_t                        dly_tag [0:`PSL_BRLAT_MAX];
  half_t                       lo_data_q;
  half_par_t                   lo_par_q;

  always_ff @(posedge ha_pclock) begin
    if (host_brvalid) begin
      tag_mem[wr_ptr] <= host_brtag;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (host_brvalid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  assign lo_issue = (br_half == half_lo) && (wr_ptr != rd_ptr);
  assign hi_issue = (br_half == half_hi);

  // two half reads per queued tag, back to back
  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      br_half     <= half_lo;
      rd_ptr      <= '0;
      afu_brvalid <= 1'b0;
    end else begin
      afu_brvalid <= lo_issue || hi_issue;
      if (lo_issue) begin
        br_half <= half_hi;
      end else if (hi_issue) begin
        br_half <= half_lo;
        rd_ptr  <= rd_ptr + 1'b1;
      end
    end
  end

  // tag is held across both halves
  always_ff @(posedge ha_pclock) begin
    if (lo_issue) begin
      afu_brtag <= tag_mem[rd_ptr];
    end
    if (lo_issue || hi_issue) begin
      afu_brad <= br_half;
    end
  end

  // entry loaded at stage brlat reaches stage 0 brlat+1 cycles after the lo request
  assign rd_load = afu_brvalid && (afu_brad == half_lo);

  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      dly_valid <= '0;
    end else begin
      for (int i = 0; i < `PSL_BRLAT_MAX; i++) begin
        if (rd_load && (afu_brlat == brlat_t'(i))) begin
          dly_valid[i] <= 1'b1;
        end else begin
          dly_valid[i] <= dly_valid[i+1];
        end
      end
      dly_valid[`PSL_BRLAT_MAX] <= rd_load && (afu_brlat == brlat_t'(`PSL_BRLAT_MAX));
    end
  end

  always_ff @(posedge ha_pclock) begin
    for (int i = 0; i < `PSL_BRLAT_MAX; i++) begin
      if (rd_load && (afu_brlat == brlat_t'(i))) begin
        dly_tag[i] <= afu_brtag;
      end else begin
        dly_tag[i] <= dly_tag[i+1];
      end
    end
    dly_tag[`PSL_BRLAT_MAX] <= afu_brtag;
  end

  // lo half arrives one cycle ahead of hi, so the previous cycle's data is kept
  always_ff @(posedge ha_pclock) begin
    lo_data_q <= afu_brdata;
    lo_par_q  <= afu_brpar;
  end

  assign host_rdvalid = dly_valid[0];
  assign host_rdtag   = dly_tag[0];
  assign host_rddata  = {afu_brdata, lo_data_q};
  assign host_rdpar   = {afu_brpar, lo_par_q};

endmodule

// ==== rtl/bw_split_queue.sv ====
`timescale 1ns/10ps
`include "psl_macros.svh"

module bw_split_queue import psl_buffer_pkg::*; (
  input  logic      ha_pclock,
  input  logic      rst,
  input  logic      host_bwvalid,
  input  tag_t      host_bwtag,
  input  line_t     host_bwdata,
  input  line_par_t host_bwpar,
  output logic      afu_bwvalid,
  output tag_t      afu_bwtag,
  output half_sel_e afu_bwad,
  output half_t     afu_bwdata,
  output half_par_t afu_bwpar,
  input  tag_t      pend_query_tag,
  output logic      pend_busy
);

  tag_t                       tag_mem  [`PSL_QDEPTH];
  line_t                      data_mem [`PSL_QDEPTH];
  line_par_t                  par_mem  [`PSL_QDEPTH];
  logic [`PSL_QDEPTH_LOG2-1:0] wr_ptr;
  logic [`PSL_QDEPTH_LOG2-1:0] rd_ptr;
  half_sel_e                  bw_half;
  logic                       bw_empty;
  logic                       lo_issue;
  logic                       hi_issue;
  tag_t                       head_tag;
  line_t                      head_data;
  line_par_t                  head_par;
  logic [`PSL_PEND_W-1:0]     pend_cnt [`PSL_TAG_NUM];
  logic [`PSL_TAG_NUM-1:0]    inc_onehot;
  logic [`PSL_TAG_NUM-1:0]    dec_onehot;

  // line storage, written on every host pulse
  always_ff @(posedge ha_pclock) begin
    if (host_bwvalid) begin
      tag_mem[wr_ptr]  <= host_bwtag;
      data_mem[wr_ptr] <= host_bwdata;
      par_mem[wr_ptr]  <= host_bwpar;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (host_bwvalid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  assign bw_empty  = (wr_ptr == rd_ptr);
  assign head_tag  = tag_mem[rd_ptr];
  assign head_data = data_mem[rd_ptr];
  assign head_par  = par_mem[rd_ptr];

  // lo half starts a line, hi half always follows on the next cycle
  assign lo_issue = (bw_half == half_lo) && !bw_empty;
  assign hi_issue = (bw_half == half_hi);

  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      bw_half     <= half_lo;
      rd_ptr      <= '0;
      afu_bwvalid <= 1'b0;
    end else begin
      afu_bwvalid <= lo_issue || hi_issue;
      if (lo_issue) begin
        bw_half <= half_hi;
      end else if (hi_issue) begin
        bw_half <= half_lo;
        rd_ptr  <= rd_ptr + 1'b1;
      end
    end
  end

  // half 0 carries the low data bits and parity bits 0 to 7
  always_ff @(posedge ha_pclock) begin
    if (lo_issue || hi_issue) begin
      afu_bwtag <= head_tag;
      afu_bwad  <= bw_half;
      if (bw_half == half_lo) begin
        afu_bwdata <= head_data[0 +: `PSL_HALF_W];
        afu_bwpar  <= head_par[0 +: `PSL_HALF_PAR_W];
      end else begin
        afu_bwdata <= head_data[`PSL_HALF_W +: `PSL_HALF_W];
        afu_bwpar  <= head_par[`PSL_HALF_PAR_W +: `PSL_HALF_PAR_W];
      end
    end
  end

  // per-tag pending writes, up on enqueue and down on the hi half
  assign inc_onehot = host_bwvalid ? (256'(1) << host_bwtag) : '0;
  assign dec_onehot = hi_issue ? (256'(1) << head_tag) : '0;

  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      for (int t = 0; t < `PSL_TAG_NUM; t++) begin
        pend_cnt[t] <= '0;
      end
    end else begin
      for (int t = 0; t < `PSL_TAG_NUM; t++) begin
        case ({inc_onehot[t], dec_onehot[t]})
          2'b10:   pend_cnt[t] <= pend_cnt[t] + 1'b1;
          2'b01:   pend_cnt[t] <= pend_cnt[t] - 1'b1;
          default: pend_cnt[t] <= pend_cnt[t];
        endcase
      end
    end
  end

  assign pend_busy = (pend_cnt[pend_query_tag] != '0);

endmodule

// ==== rtl/psl_buffer_pkg.sv ====
`include "psl_macros.svh"

package psl_buffer_pkg;

  typedef logic [`PSL_TAG_W-1:0] tag_t;

  // host line and accelerator half
  typedef logic [`PSL_LINE_W-1:0] line_t;
  typedef logic [`PSL_HALF_W-1:0] half_t;

  typedef logic [`PSL_LINE_PAR_W-1:0] line_par_t;
  typedef logic [`PSL_HALF_PAR_W-1:0] half_par_t;

  // which half of a line is on the bus
  typedef enum logic {
    half_lo = 1'b0,
    half_hi = 1'b1
  } half_sel_e;

  typedef logic [`PSL_BRLAT_W-1:0] brlat_t;

endpackage

// ==== rtl/psl_buffer_top.sv ====
`timescale 1ns/10ps
`include "psl_macros.svh"

module psl_buffer_top
  import psl_buffer_pkg::*;
  import psl_response_pkg::*;
(
  input  logic       ha_pclock,
  input  logic       rst,
  // host write
  input  logic       host_bwvalid,
  input  tag_t       host_bwtag,
  input  line_t      host_bwdata,
  input  line_par_t  host_bwpar,
  // host read
  input  logic       host_brvalid,
  input  tag_t       host_brtag,
  output logic       host_rdvalid,
  output tag_t       host_rdtag,
  output line_t      host_rddata,
  output line_par_t  host_rdpar,
  // host response
  input  logic       host_rvalid,
  input  tag_t       host_rtag,
  input  resp_code_e host_response,
  input  credits_t   host_rcredits,
  // accelerator write
  output logic       afu_bwvalid,
  output tag_t       afu_bwtag,
  output half_sel_e  afu_bwad,
  output half_t      afu_bwdata,
  output half_par_t  afu_bwpar,
  // accelerator read
  output logic       afu_brvalid,
  output tag_t       afu_brtag,
  output half_sel_e  afu_brad,
  input  brlat_t     afu_brlat,
  input  half_t      afu_brdata,
  input  half_par_t  afu_brpar,
  // accelerator response
  output logic       afu_rvalid,
  output tag_t       afu_rtag,
  output resp_code_e afu_response,
  output credits_t   afu_rcredits
);

  // response head tag and the write path's answer
  tag_t pend_query_tag;
  logic pend_busy;

  bw_split_queue u_bw_split_queue (
    .ha_pclock      (ha_pclock),
    .rst            (rst),
    .host_bwvalid   (host_bwvalid),
    .host_bwtag     (host_bwtag),
    .host_bwdata    (host_bwdata),
    .host_bwpar     (host_bwpar),
    .afu_bwvalid    (afu_bwvalid),
    .afu_bwtag      (afu_bwtag),
    .afu_bwad       (afu_bwad),
    .afu_bwdata     (afu_bwdata),
    .afu_bwpar      (afu_bwpar),
    .pend_query_tag (pend_query_tag),
    .pend_busy      (pend_busy)
  );

  br_latency_queue u_br_latency_queue (
    .ha_pclock    (ha_pclock),
    .rst          (rst),
    .host_brvalid (host_brvalid),
    .host_brtag   (host_brtag),
    .host_rdvalid (host_rdvalid),
    .host_rdtag   (host_rdtag),
    .host_rddata  (host_rddata),
    .host_rdpar   (host_rdpar),
    .afu_brvalid  (afu_brvalid),
    .afu_brtag    (afu_brtag),
    .afu_brad     (afu_brad),
    .afu_brlat    (afu_brlat),
    .afu_brdata   (afu_brdata),
    .afu_brpar    (afu_brpar)
  );

  resp_hold_queue u_resp_hold_queue (
    .ha_pclock      (ha_pclock),
    .rst            (rst),
    .host_rvalid    (host_rvalid),
    .host_rtag      (host_rtag),
    .host_response  (host_response),
    .host_rcredits  (host_rcredits),
    .afu_rvalid     (afu_rvalid),
    .afu_rtag       (afu_rtag),
    .afu_response   (afu_response),
    .afu_rcredits   (afu_rcredits),
    .pend_query_tag (pend_query_tag),
    .pend_busy      (pend_busy)
  );

endmodule

// ==== rtl/psl_macros.svh ====
`ifndef PSL_MACROS_SVH
`define PSL_MACROS_SVH

// buffer tag and data widths
`define PSL_TAG_W        8
`define PSL_TAG_NUM      256
`define PSL_LINE_W       1024
`define PSL_HALF_W       512
`define PSL_LINE_PAR_W   16
`define PSL_HALF_PAR_W   8

// queue sizing, 64 entries per path
`define PSL_QDEPTH_LOG2  6
`define PSL_QDEPTH       64

// read latency code and response delay
`define PSL_BRLAT_W      4
`define PSL_BRLAT_MAX    15
`define PSL_RESP_DELAY   3

// response fields and write pending count
`define PSL_RESP_CODE_W  8
`define PSL_CREDITS_W    9
`define PSL_PEND_W       2

`endif

// ==== rtl/psl_response_pkg.sv ====
`include "psl_macros.svh"

package psl_response_pkg;

  // response opcodes as seen by the accelerator
  typedef enum logic [`PSL_RESP_CODE_W-1:0] {
    resp_done    = 8'h00,
    resp_aerror  = 8'h01,
    resp_derror  = 8'h03,
    resp_flushed = 8'h06,
    resp_fault   = 8'h07,
    resp_failed  = 8'h08
  } resp_code_e;

  typedef logic [`PSL_CREDITS_W-1:0] credits_t;

endpackage

// ==== rtl/resp_hold_queue.sv ====
`timescale 1ns/10ps
`include "psl_macros.svh"

module resp_hold_queue
  import psl_buffer_pkg::*;
  import psl_response_pkg::*;
(
  input  logic       ha_pclock,
  input  logic       rst,
  input  logic       host_rvalid,
  input  tag_t       host_rtag,
  input  resp_code_e host_response,
  input  credits_t   host_rcredits,
  output logic       afu_rvalid,
  output tag_t       afu_rtag,
  output resp_code_e afu_response,
  output credits_t   afu_rcredits,
  output tag_t       pend_query_tag,
  input  logic       pend_busy
);

  tag_t                        tag_mem  [`PSL_QDEPTH];
  resp_code_e                  code_mem [`PSL_QDEPTH];
  credits_t                    cred_mem [`PSL_QDEPTH];
  logic [`PSL_QDEPTH_LOG2-1:0] wr_ptr;
  logic [`PSL_QDEPTH_LOG2-1:0] rd_ptr;
  logic                        release_head;
  logic                        rel_valid;
  tag_t                        rel_tag;
  resp_code_e                  rel_code;
  credits_t                    rel_credits;
  logic [`PSL_RESP_DELAY-1:0]  pipe_valid;
  tag_t                        pipe_tag     [`PSL_RESP_DELAY];
  resp_code_e                  pipe_code    [`PSL_RESP_DELAY];
  credits_t                    pipe_credits [`PSL_RESP_DELAY];

  always_ff @(posedge ha_pclock) begin
    if (host_rvalid) begin
      tag_mem[wr_ptr]  <= host_rtag;
      code_mem[wr_ptr] <= host_response;
      cred_mem[wr_ptr] <= host_rcredits;
    end
  end

  // head waits while its tag still has write halves queued
  assign pend_query_tag = tag_mem[rd_ptr];
  assign release_head   = (wr_ptr != rd_ptr) && !pend_busy;

  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      rel_valid <= 1'b0;
    end else begin
      if (host_rvalid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (release_head) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      rel_valid <= release_head;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (release_head) begin
      rel_tag     <= tag_mem[rd_ptr];
      rel_code    <= code_mem[rd_ptr];
      rel_credits <= cred_mem[rd_ptr];
    end
  end

  // fixed delay, several responses may be in flight
  always_ff @(posedge ha_pclock) begin
    if (rst) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid <= {pipe_valid[`PSL_RESP_DELAY-2:0], rel_valid};
    end
  end

  always_ff @(posedge ha_pclock) begin
    pipe_tag[0]     <= rel_tag;
    pipe_code[0]    <= rel_code;
    pipe_credits[0] <= rel_credits;
    for (int i = 1; i < `PSL_RESP_DELAY; i++) begin
      pipe_tag[i]     <= pipe_tag[i-1];
      pipe_code[i]    <= pipe_code[i-1];
      pipe_credits[i] <= pipe_credits[i-1];
    end
  end

  assign afu_rvalid   = pipe_valid[`PSL_RESP_DELAY-1];
  assign afu_rtag     = pipe_tag[`PSL_RESP_DELAY-1];
  assign afu_response = pipe_code[`PSL_RESP_DELAY-1];
  assign afu_rcredits = pipe_credits[`PSL_RESP_DELAY-1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
  --top-module tb_psl_buffer -Mdir obj_dir -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1

// ==== verification/tb_psl_buffer.sv ====
`timescale 1ns/10ps
`include "psl_macros.svh"

module tb_psl_buffer
  import psl_buffer_pkg::*;
  import psl_response_pkg::*;
();

  localparam int NUM_ENTRIES    = 30;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40 + 200;
  // enqueue capture, release, then the delay stages
  localparam int RESP_PROMPT    = `PSL_RESP_DELAY + 2;
  localparam int RD_SLOTS       = 32;

  typedef enum {k_idle, k_write, k_read, k_resp} kind_e;

  typedef struct {
    kind_e       kind;
    tag_t        tag;
    logic [31:0] dseed;
    brlat_t      brlat;
    resp_code_e  code;
    credits_t    credits;
  } stim_t;

  typedef struct {
    tag_t      tag;
    half_sel_e half;
    half_t     data;
    half_par_t par;
  } wr_exp_t;

  typedef struct {
    tag_t tag;
    int   due;
  } rd_exp_t;

  typedef struct {
    tag_t       tag;
    resp_code_e code;
    credits_t   credits;
    int         hi_need;
    int         due;
  } resp_exp_t;

  logic       ha_pclock = 1'b0;
  logic       rst;
  logic       host_bwvalid;
  tag_t       host_bwtag;
  line_t      host_bwdata;
  line_par_t  host_bwpar;
  logic       host_brvalid;
  tag_t       host_brtag;
  logic       host_rdvalid;
  tag_t       host_rdtag;
  line_t      host_rddata;
  line_par_t  host_rdpar;
  logic       host_rvalid;
  tag_t       host_rtag;
  resp_code_e host_response;
  credits_t   host_rcredits;
  logic       afu_bwvalid;
  tag_t       afu_bwtag;
  half_sel_e  afu_bwad;
  half_t      afu_bwdata;
  half_par_t  afu_bwpar;
  logic       afu_brvalid;
  tag_t       afu_brtag;
  half_sel_e  afu_brad;
  brlat_t     afu_brlat;
  half_t      afu_brdata = '0;
  half_par_t  afu_brpar = '0;
  logic       afu_rvalid;
  tag_t       afu_rtag;
  resp_code_e afu_response;
  credits_t   afu_rcredits;

  stim_t     stim_table [NUM_ENTRIES];
  wr_exp_t   wr_exp_q [$];
  tag_t      rd_req_q [$];
  rd_exp_t   rd_exp_q [$];
  resp_exp_t resp_exp_q [$];
  int        wr_in_cnt  [`PSL_TAG_NUM];
  int        hi_out_cnt [`PSL_TAG_NUM];
  bit        slot_valid [RD_SLOTS];
  half_t     slot_data  [RD_SLOTS];
  half_par_t slot_par   [RD_SLOTS];
  logic      hi_pending = 1'b0;
  tag_t      hi_tag;
  integer    seed = 32'hcf0e;
  int        cycle_cnt = 0;
  int        pass_cnt = 0;
  int        fail_cnt = 0;

  psl_buffer_top u_psl_buffer_top (.*);

  always #4 ha_pclock = ~ha_pclock;

  always @(posedge ha_pclock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic load_table();
    stim_table[0]  = '{k_write, 8'h11, 32'h0000_0000, 4'd1,  resp_done,    9'd0};
    stim_table[1]  = '{k_write, 8'h12, 32'ha5a5_a5a5, 4'd1,  resp_done,    9'd0};
    stim_table[2]  = '{k_resp,  8'h11, 32'h0,         4'd1,  resp_done,    9'd1};
    stim_table[3]  = '{k_resp,  8'h20, 32'h0,         4'd1,  resp_aerror,  9'd2};
    stim_table[4]  = '{k_read,  8'h40, 32'h0,         4'd1,  resp_done,    9'd0};
    stim_table[5]  = '{k_read,  8'h41, 32'h0,         4'd1,  resp_done,    9'd0};
    stim_table[6]  = '{k_write, 8'h11, 32'h1234_5678, 4'd1,  resp_done,    9'd0};
    stim_table[7]  = '{k_resp,  8'h11, 32'h0,         4'd1,  resp_derror,  9'd3};
    stim_table[8]  = '{k_idle,  8'h00, 32'h0,         4'd1,  resp_done,    9'd0};
    stim_table[9]  = '{k_read,  8'h42, 32'h0,         4'd4,  resp_done,    9'd0};
    stim_table[10] = '{k_read,  8'h43, 32'h0,         4'd4,  resp_done,    9'd0};
    stim_table[11] = '{k_read,  8'h44, 32'h0,         4'd4,  resp_done,    9'd0};
    stim_table[12] = '{k_idle,  8'h00, 32'h0,         4'd4,  resp_done,    9'd0};
    stim_table[13] = '{k_write, 8'h54, 32'h7777_1111, 4'd4,  resp_done,    9'd0};
    stim_table[14] = '{k_write, 8'h55, 32'h9999_2222, 4'd4,  resp_done,    9'd0};
    stim_table[15] = '{k_write, 8'h50, 32'h0f0f_0f0f, 4'd4,  resp_done,    9'd0};
    stim_table[16] = '{k_write, 8'h51, 32'hf0f0_f0f0, 4'd4,  resp_done,    9'd0};
    stim_table[17] = '{k_write, 8'h52, 32'h3c3c_3c3c, 4'd4,  resp_done,    9'd0};
    stim_table[18] = '{k_write, 8'h53, 32'hdead_beef, 4'd4,  resp_done,    9'd0};
    stim_table[19] = '{k_resp,  8'h60, 32'h0,         4'd4,  resp_fault,   9'd5};
    stim_table[20] = '{k_resp,  8'h53, 32'h0,         4'd4,  resp_flushed, 9'd6};
    stim_table[21] = '{k_resp,  8'h12, 32'h0,         4'd4,  resp_done,    9'd7};
    stim_table[22] = '{k_read,  8'h45, 32'h0,         4'd15, resp_done,    9'd0};
    stim_table[23] = '{k_read,  8'h46, 32'h0,         4'd15, resp_done,    9'd0};
    stim_table[24] = '{k_write, 8'h12, 32'h5555_aaaa, 4'd15, resp_done,    9'd0};
    stim_table[25] = '{k_resp,  8'h12, 32'h0,         4'd15, resp_failed,  9'd8};
    stim_table[26] = '{k_idle,  8'h00, 32'h0,         4'd15, resp_done,    9'd0};
    stim_table[27] = '{k_read,  8'h47, 32'h0,         4'd1,  resp_done,    9'd0};
    stim_table[28] = '{k_resp,  8'h47, 32'h0,         4'd1,  resp_done,    9'h1ff};
    stim_table[29] = '{k_write, 8'h47, 32'h0bad_f00d, 4'd1,  resp_done,    9'd0};
  endtask

  // accelerator read data is a fixed function of tag and half
  function automatic half_t model_half(input tag_t tag, input half_sel_e half);
    half_t h;
    for (int w = 0; w < `PSL_HALF_W / 32; w++) begin
      h[w*32 +: 32] = {tag, 8'(w), (half == half_hi) ? 8'hc3 : 8'h3c, tag ^ 8'(w * 17)};
    end
    return h;
  endfunction

  function automatic half_par_t model_par(input tag_t tag, input half_sel_e half);
    return tag ^ ((half == half_hi) ? 8'hf0 : 8'h0f);
  endfunction

  task automatic note_pass(input string what);
    $display("ok %s", what);
    pass_cnt++;
  endtask

  task automatic report_mismatch(input string what);
    $display("MISMATCH at %0t: %s", $time, what);
    fail_cnt++;
  endtask

  task automatic describe_failure(input string what);
    $display("FAILED at %0t: %s", $time, what);
    fail_cnt++;
  endtask

  task automatic check_half(input tag_t exp_tag, input half_sel_e exp_half,
                            input half_t exp_data, input half_par_t exp_par);
    if (afu_bwtag !== exp_tag || afu_bwad !== exp_half ||
        afu_bwdata !== exp_data || afu_bwpar !== exp_par) begin
      report_mismatch($sformatf("write %0h/%0d: got tag %0h half %0d par %0h (exp %0h), data %s",
                                exp_tag, exp_half, afu_bwtag, afu_bwad, afu_bwpar, exp_par,
                                (afu_bwdata === exp_data) ? "ok" : "wrong"));
    end else begin
      note_pass($sformatf("write tag %0h half %0d", exp_tag, exp_half));
    end
  endtask

  task automatic check_read_req(input tag_t exp_tag, input half_sel_e exp_half);
    if (afu_brtag !== exp_tag || afu_brad !== exp_half) begin
      report_mismatch($sformatf("read request: got tag %0h half %0d, expected tag %0h half %0d",
                                afu_brtag, afu_brad, exp_tag, exp_half));
    end else begin
      note_pass($sformatf("read request tag %0h half %0d", exp_tag, exp_half));
    end
  endtask

  task automatic check_line(input tag_t exp_tag, input line_t exp_data, input line_par_t exp_par);
    if (host_rdtag !== exp_tag || host_rddata !== exp_data || host_rdpar !== exp_par) begin
      report_mismatch($sformatf("read line tag %0h: got tag %0h par %0h (exp %0h), data %s",
                                exp_tag, host_rdtag, host_rdpar, exp_par,
                                (host_rddata === exp_data) ? "ok" : "wrong"));
    end else begin
      note_pass($sformatf("read line tag %0h", exp_tag));
    end
  endtask

  task automatic check_resp(input tag_t exp_tag, input resp_code_e exp_code,
                            input credits_t exp_credits);
    if (afu_rtag !== exp_tag || afu_response !== exp_code || afu_rcredits !== exp_credits) begin
      report_mismatch($sformatf("response: got tag %0h code %0h credits %0d, expected %0h %0h %0d",
                                afu_rtag, afu_response, afu_rcredits,
                                exp_tag, exp_code, exp_credits));
    end else begin
      note_pass($sformatf("response tag %0h code %0h", exp_tag, exp_code));
    end
  endtask

  task automatic apply_write(input stim_t e);
    line_t     d;
    line_par_t p;
    for (int w = 0; w < `PSL_LINE_W / 32; w++) begin
      d[w*32 +: 32] = $random(seed) ^ e.dseed;
    end
    p = 16'($random(seed));
    host_bwvalid = 1'b1;
    host_bwtag   = e.tag;
    host_bwdata  = d;
    host_bwpar   = p;
    // half 0 takes the low data bits and parity bits 0 to 7
    wr_exp_q.push_back('{e.tag, half_lo, d[0 +: `PSL_HALF_W], p[0 +: `PSL_HALF_PAR_W]});
    wr_exp_q.push_back('{e.tag, half_hi, d[`PSL_HALF_W +: `PSL_HALF_W],
                         p[`PSL_HALF_PAR_W +: `PSL_HALF_PAR_W]});
    wr_in_cnt[e.tag]++;
  endtask

  task automatic apply_read(input stim_t e);
    host_brvalid = 1'b1;
    host_brtag   = e.tag;
    rd_req_q.push_back(e.tag);
  endtask

  task automatic apply_resp(input stim_t e);
    resp_exp_t r;
    r.tag     = e.tag;
    r.code    = e.code;
    r.credits = e.credits;
    r.hi_need = wr_in_cnt[e.tag];
    // nothing ahead and no write pending for the tag, so no hold at all
    if (resp_exp_q.size() == 0 && wr_in_cnt[e.tag] == hi_out_cnt[e.tag]) begin
      r.due = cycle_cnt + RESP_PROMPT;
    end else begin
      r.due = -1;
    end
    host_rvalid   = 1'b1;
    host_rtag     = e.tag;
    host_response = e.code;
    host_rcredits = e.credits;
    resp_exp_q.push_back(r);
  endtask

  task automatic clear_strobes();
    host_bwvalid = 1'b0;
    host_brvalid = 1'b0;
    host_rvalid  = 1'b0;
  endtask

  function automatic bit reads_busy();
    return rd_req_q.size() != 0 || rd_exp_q.size() != 0 || hi_pending;
  endfunction

  function automatic bit work_outstanding();
    return reads_busy() || wr_exp_q.size() != 0 || resp_exp_q.size() != 0;
  endfunction

  task automatic check_idle();
    logic seen;
    seen = 1'b0;
    repeat (6) begin
      @(negedge ha_pclock);
      if ({afu_bwvalid, afu_brvalid, afu_rvalid, host_rdvalid} !== 4'b0000) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      describe_failure("a valid output went high after reset with no stimulus");
    end else begin
      note_pass("valid outputs idle after reset");
    end
  endtask

  // read model, each half answered afu_brlat cycles after its request
  task automatic drive_read_data();
    int s;
    s = cycle_cnt % RD_SLOTS;
    afu_brdata = slot_valid[s] ? slot_data[s] : '0;
    afu_brpar  = slot_valid[s] ? slot_par[s] : '0;
    slot_valid[s] = 1'b0;
  endtask

  task automatic answer_read_req();
    int s;
    s = (cycle_cnt + int'(afu_brlat)) % RD_SLOTS;
    if (afu_brvalid === 1'b1) begin
      slot_valid[s] = 1'b1;
      slot_data[s]  = model_half(afu_brtag, afu_brad);
      slot_par[s]   = model_par(afu_brtag, afu_brad);
    end
  endtask

  task automatic watch_writes();
    wr_exp_t x;
    if (afu_bwvalid === 1'b1) begin
      if (wr_exp_q.size() == 0) begin
        describe_failure("afu_bwvalid went high with no host write queued");
      end else begin
        x = wr_exp_q.pop_front();
        check_half(x.tag, x.half, x.data, x.par);
        if (x.half == half_hi) begin
          hi_out_cnt[x.tag]++;
        end
      end
    end
  endtask

  task automatic watch_read_req();
    tag_t t;
    if (hi_pending) begin
      hi_pending = 1'b0;
      if (afu_brvalid !== 1'b1) begin
        describe_failure($sformatf("half_hi read request for tag %0h did not follow", hi_tag));
      end else begin
        check_read_req(hi_tag, half_hi);
      end
    end else if (afu_brvalid === 1'b1) begin
      if (rd_req_q.size() == 0) begin
        describe_failure("afu_brvalid went high with no host read queued");
      end else begin
        t = rd_req_q.pop_front();
        check_read_req(t, half_lo);
        hi_pending = 1'b1;
        hi_tag     = t;
        rd_exp_q.push_back('{t, cycle_cnt + int'(afu_brlat) + 1});
      end
    end
  endtask

  task automatic watch_read_cpl();
    rd_exp_t c;
    if (host_rdvalid === 1'b1) begin
      if (rd_exp_q.size() == 0) begin
        describe_failure("host_rdvalid went high with no read in flight");
      end else begin
        c = rd_exp_q.pop_front();
        if (cycle_cnt != c.due) begin
          describe_failure($sformatf("read tag %0h completed at cycle %0d instead of cycle %0d",
                                     c.tag, cycle_cnt, c.due));
        end
        check_line(c.tag, {model_half(c.tag, half_hi), model_half(c.tag, half_lo)},
                   {model_par(c.tag, half_hi), model_par(c.tag, half_lo)});
      end
    end else if (rd_exp_q.size() != 0 && rd_exp_q[0].due < cycle_cnt) begin
      describe_failure($sformatf("read completion for tag %0h never arrived", rd_exp_q[0].tag));
      rd_exp_q.delete(0);
    end
  endtask

  task automatic watch_resp();
    resp_exp_t r;
    if (afu_rvalid === 1'b1) begin
      if (resp_exp_q.size() == 0) begin
        describe_failure("afu_rvalid went high with no response queued");
      end else begin
        r = resp_exp_q.pop_front();
        check_resp(r.tag, r.code, r.credits);
        if (hi_out_cnt[r.tag] < r.hi_need) begin
          describe_failure($sformatf("response for tag %0h overtook a queued write", r.tag));
        end
        if (r.due >= 0 && cycle_cnt != r.due) begin
          describe_failure($sformatf("response for tag %0h was held, arrived at cycle %0d not %0d",
                                     r.tag, cycle_cnt, r.due));
        end
      end
    end
  endtask

  // inputs change on the falling edge, outputs are sampled 1 ns later
  always @(negedge ha_pclock) begin
    drive_read_data();
    #1;
    if (!rst) begin
      answer_read_req();
      watch_resp();
      watch_writes();
      watch_read_req();
      watch_read_cpl();
    end
  end

  initial begin
    rst           = 1'b1;
    host_bwvalid  = 1'b0;
    host_bwtag    = '0;
    host_bwdata   = '0;
    host_bwpar    = '0;
    host_brvalid  = 1'b0;
    host_brtag    = '0;
    host_rvalid   = 1'b0;
    host_rtag     = '0;
    host_response = resp_done;
    host_rcredits = '0;
    afu_brlat     = 4'd1;
    load_table();
    repeat (10) @(negedge ha_pclock);
    rst = 1'b0;
    check_idle();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(negedge ha_pclock);
      clear_strobes();
      // latency only changes once no read is in flight
      if (stim_table[i].kind == k_read && stim_table[i].brlat != afu_brlat) begin
        while (reads_busy()) begin
          @(negedge ha_pclock);
        end
        afu_brlat = stim_table[i].brlat;
      end
      case (stim_table[i].kind)
        k_write: apply_write(stim_table[i]);
        k_read:  apply_read(stim_table[i]);
        k_resp:  apply_resp(stim_table[i]);
        default: clear_strobes();
      endcase
    end
    @(negedge ha_pclock);
    clear_strobes();
    while (work_outstanding()) begin
      @(negedge ha_pclock);
    end
    // a few more cycles to catch stray valids
    repeat (RESP_PROMPT + 2) @(negedge ha_pclock);
    $display("%0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
